//--- Bender.yml
package:
  name: udp_traffic

sources:
  - logic/udp_traffic_pkg.sv
  - logic/payload_fifo_if.sv
  - logic/udp_traffic_ctrl.sv
  - logic/payload_gen.sv
  - logic/payload_fifo.sv
  - logic/mac_tx_streamer.sv
  - logic/rx_frame_checker.sv
  - logic/udp_traffic_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_udp_traffic.sv

//--- flist.f
+incdir+tests
logic/udp_traffic_pkg.sv
logic/payload_fifo_if.sv
logic/udp_traffic_ctrl.sv
logic/payload_gen.sv
logic/payload_fifo.sv
logic/mac_tx_streamer.sv
logic/rx_frame_checker.sv
logic/udp_traffic_top.sv
tests/tb_udp_traffic.sv

//--- tests/udp_traffic_model.svh
`ifndef UDP_TRAFFIC_MODEL_SVH
`define UDP_TRAFFIC_MODEL_SVH

// --------------------------------------------------
// Random source
// --------------------------------------------------
logic [31:0] lcg_state = 32'hd2dd;      // Fixed seed
logic [31:0] rx_frame [FRAME_WORDS];    // Receive frame under construction

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
	return lcg_state;
endfunction

// --------------------------------------------------
// Payload and checksum model
// --------------------------------------------------
// Word k of the payload for packet pkt, bytes past the end zeroed
function automatic logic [31:0] model_word(input logic [63:0] pkt, input int k);
	logic [31:0] w;
	logic [7:0]  step;
	step = 8'(BYTE_STEP * (k - 2));          // Rise since the pattern word
	if (k == 0)
		w = pkt[63:32];
	else if (k == 1)
		w = pkt[31:0];
	else
		for (int j = 0; j < WORD_BYTES; j++)
			w[8*j +: 8] = TEST_PATTERN[8*j +: 8] + step;
	// Byte 3 is first on the wire
	for (int j = 0; j < WORD_BYTES; j++)
		if (WORD_BYTES * k + (WORD_BYTES - 1 - j) >= P_BYTES)
			w[8*j +: 8] = 8'h00;
	return w;
endfunction

// Wide accumulate, then fold carries back in
function automatic logic [15:0] fold16(input logic [31:0] acc);
	while (acc[31:16] != 16'd0)
		acc = {16'd0, acc[31:16]} + {16'd0, acc[15:0]};
	return acc[15:0];
endfunction

function automatic logic [15:0] model_csum(input logic [63:0] pkt);
	logic [31:0] acc;
	logic [31:0] w;
	acc = '0;
	for (int k = 0; k < FRAME_WORDS; k++)
	begin
		w   = model_word(pkt, k);
		acc = acc + w[31:16] + w[15:0];
	end
	return fold16(acc);
endfunction

// Receive frame with sequence in the low half of word 1
// Last word holds the two valid bytes that close the sum to all ones
task automatic build_rx_frame(input logic [15:0] seq, input logic [15:0] filler);
	logic [31:0] acc;
	logic [31:0] w;
	acc = '0;
	for (int k = 0; k < FRAME_WORDS - 1; k++)
	begin
		w           = model_word({48'd0, seq}, k);
		rx_frame[k] = w;
		acc         = acc + w[31:16] + w[15:0];
	end
	rx_frame[FRAME_WORDS-1] = {~fold16(acc), filler};   // Filler lies past be, not summed
endtask

`endif

//--- tests/tb_udp_traffic.sv
`timescale 1ns/1ns

module tb_udp_traffic import udp_traffic_pkg::*;;

	localparam int         P_BYTES     = 22;
	localparam int         P_GAP       = 20;
	localparam int         P_HOLD      = 50;
	localparam int         P_AW        = 4;
	localparam int         FRAME_WORDS = 6;       // 22 bytes span six words
	localparam logic [1:0] LAST_BE     = 2'd2;    // Two valid bytes in the sixth word
	localparam int         TX_TIMEOUT  = 300;   // Cycles allowed per packet

	logic        pll_62_5m_clk = 1'b0;
	logic        rst_n;
	logic        tx_wa_i;
	logic        tx_wr_o;
	logic [31:0] tx_data_o;
	logic [1:0]  tx_be_o;
	logic        tx_sop_o;
	logic        tx_eop_o;
	logic [15:0] tx_csum_o;
	logic        rx_pa_i;
	logic [31:0] rx_data_i;
	logic [1:0]  rx_be_i;
	logic        rx_sop_i;
	logic        rx_eop_i;
	logic        seq_err_o;
	logic        csum_err_o;
	logic        act_o;

	int          err_cnt      = 0;
	int          csum_err_cnt = 0;   // Checksum part of the error count
	int          tests_run    = 0;
	int          tests_failed = 0;
	logic [63:0] next_pkt     = '0;  // Expected packet number
	logic [15:0] rx_frames    = '0;  // Frames sent to the checker

	`include "udp_traffic_model.svh"

	always #100 pll_62_5m_clk = ~pll_62_5m_clk;   // 200 ns period

	udp_traffic_top #(
		.PAYLOAD_BYTES   (P_BYTES),
		.GAP_CYCLES      (P_GAP),
		.LED_HOLD_CYCLES (P_HOLD),
		.FIFO_AW         (P_AW)
	) dut (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.tx_wa_i       (tx_wa_i),
		.tx_wr_o       (tx_wr_o),
		.tx_data_o     (tx_data_o),
		.tx_be_o       (tx_be_o),
		.tx_sop_o      (tx_sop_o),
		.tx_eop_o      (tx_eop_o),
		.tx_csum_o     (tx_csum_o),
		.rx_pa_i       (rx_pa_i),
		.rx_data_i     (rx_data_i),
		.rx_be_i       (rx_be_i),
		.rx_sop_i      (rx_sop_i),
		.rx_eop_i      (rx_eop_i),
		.seq_err_o     (seq_err_o),
		.csum_err_o    (csum_err_o),
		.act_o         (act_o)
	);

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	task automatic report_error(input string msg);
		$display("** Error at %0t ns: %s", $time, msg);
		err_cnt++;
	endtask

	task automatic finish_test(input string name, input int errs);
		tests_run++;
		if (errs == 0)
			$display("%-26s passed", name);
		else
		begin
			$display("%-26s failed with %0d errors", name, errs);
			tests_failed++;
		end
	endtask

	// One packet off the MAC write port, checked word by word
	task automatic collect_packet(input logic random_wa);
		int          idx;
		int          cycles;
		logic        done;
		logic [31:0] r;
		logic [31:0] exp_w;
		logic [15:0] exp_csum;
		idx      = 0;
		cycles   = 0;
		done     = 1'b0;
		exp_csum = model_csum(next_pkt);
		while (!done && cycles < TX_TIMEOUT)
		begin
			@(posedge pll_62_5m_clk);
			r = lcg_next();
			if (random_wa)
				tx_wa_i <= r[27];             // About half the cycles allowed
			@(negedge pll_62_5m_clk);           // Outputs settled mid cycle
			cycles++;
			if (tx_wr_o && !tx_wa_i)
				report_error("tx_wr_o high while tx_wa_i low");
			if (tx_wr_o)
			begin
				exp_w = model_word(next_pkt, idx);
				if (tx_data_o !== exp_w)
					report_error($sformatf("packet %0d word %0d is %h, expected %h",
						next_pkt, idx, tx_data_o, exp_w));
				if (tx_sop_o !== (idx == 0))
					report_error($sformatf("packet %0d word %0d has sop %b",
						next_pkt, idx, tx_sop_o));
				if (tx_eop_o !== (idx == FRAME_WORDS - 1))
					report_error($sformatf("packet %0d word %0d has eop %b",
						next_pkt, idx, tx_eop_o));
				if (idx == FRAME_WORDS - 1)
				begin
					if (tx_be_o !== LAST_BE)
						report_error($sformatf("packet %0d eop be is %0d, expected %0d",
							next_pkt, tx_be_o, LAST_BE));
					if (tx_csum_o !== exp_csum)
					begin
						report_error($sformatf("packet %0d checksum is %h, expected %h",
							next_pkt, tx_csum_o, exp_csum));
						csum_err_cnt++;
					end
					done = 1'b1;                // Stay aligned to the frame length
				end
				idx++;
			end
		end
		if (!done)
		begin
			$display("Timeout: packet %0d did not finish within %0d cycles",
				next_pkt, TX_TIMEOUT);
			err_cnt++;
		end
		next_pkt++;
	endtask

	// One frame into the MAC read port, words back to back
	task automatic send_rx_frame(input logic [15:0] seq, input logic corrupt,
		input logic check_act);
		logic [31:0] r;
		r = lcg_next();
		build_rx_frame(seq, r[31:16]);
		if (corrupt)
			rx_frame[3][15:8] = rx_frame[3][15:8] ^ (r[7:0] | 8'h01);   // Never a no-op
		for (int i = 0; i < FRAME_WORDS; i++)
		begin
			@(posedge pll_62_5m_clk);
			rx_pa_i   <= 1'b1;
			rx_data_i <= rx_frame[i];
			rx_sop_i  <= (i == 0);
			rx_eop_i  <= (i == FRAME_WORDS - 1);
			rx_be_i   <= (i == FRAME_WORDS - 1) ? LAST_BE : 2'd0;
			@(negedge pll_62_5m_clk);
			if (check_act && i == 1 && act_o !== 1'b1)
				report_error("act_o low one cycle after the first receive word");
		end
		@(posedge pll_62_5m_clk);
		rx_pa_i  <= 1'b0;
		rx_sop_i <= 1'b0;
		rx_eop_i <= 1'b0;
		rx_be_i  <= 2'd0;
		@(negedge pll_62_5m_clk);                   // Flags of this frame now visible
		rx_frames++;
	endtask

	task automatic check_flags(input logic exp_seq, input logic exp_csum, input string when);
		if (seq_err_o !== exp_seq)
			report_error($sformatf("seq_err_o is %b %s, expected %b", seq_err_o, when, exp_seq));
		if (csum_err_o !== exp_csum)
			report_error($sformatf("csum_err_o is %b %s, expected %b", csum_err_o, when,
				exp_csum));
	endtask

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		int start;
		int cstart;
		int hold;
		rst_n     <= 1'b0;
		tx_wa_i   <= 1'b1;                      // Held high for the first packets
		rx_pa_i   <= 1'b0;
		rx_data_i <= '0;
		rx_be_i   <= 2'd0;
		rx_sop_i  <= 1'b0;
		rx_eop_i  <= 1'b0;
		repeat (3) @(posedge pll_62_5m_clk);
		rst_n <= 1'b1;

		// Payload content and checksum at full rate
		start  = err_cnt;
		cstart = csum_err_cnt;
		collect_packet(1'b0);
		collect_packet(1'b0);
		finish_test("payload content", (err_cnt - start) - (csum_err_cnt - cstart));
		finish_test("payload checksum", csum_err_cnt - cstart);

		// Random write allowed for packets 2 to 4
		start = err_cnt;
		repeat (3) collect_packet(1'b1);
		@(posedge pll_62_5m_clk);
		tx_wa_i <= 1'b0;                        // Park the transmit side
		finish_test("back-pressure", err_cnt - start);

		// Good receive frames
		start = err_cnt;
		@(negedge pll_62_5m_clk);
		check_flags(1'b0, 1'b0, "before any frame");
		send_rx_frame(rx_frames, 1'b0, 1'b1);
		send_rx_frame(rx_frames, 1'b0, 1'b0);
		send_rx_frame(rx_frames, 1'b0, 1'b0);
		check_flags(1'b0, 1'b0, "after good frames");
		if (act_o !== 1'b1)
			report_error("act_o low during receive traffic");
		finish_test("good receive frames", err_cnt - start);

		// Corrupted byte, then a skipped sequence number
		start = err_cnt;
		send_rx_frame(rx_frames, 1'b1, 1'b0);
		check_flags(1'b0, 1'b1, "after corrupted frame");
		send_rx_frame(rx_frames + 16'd1, 1'b0, 1'b0);
		check_flags(1'b1, 1'b1, "after skipped sequence");
		send_rx_frame(rx_frames, 1'b0, 1'b0);
		send_rx_frame(rx_frames, 1'b0, 1'b0);
		check_flags(1'b1, 1'b1, "over later good frames");
		finish_test("bad receive frames", err_cnt - start);

		// Activity hold
		// Cycle 1 is the negedge the last send ended on
		start = err_cnt;
		hold  = 1;
		while (hold <= P_HOLD)
		begin
			if (hold < P_HOLD && act_o !== 1'b1)
				report_error($sformatf("act_o low at cycle %0d of the hold", hold));
			if (hold == P_HOLD && act_o !== 1'b0)
				report_error($sformatf("act_o still high at cycle %0d", hold));
			if (hold < P_HOLD)
				@(negedge pll_62_5m_clk);
			hold++;
		end
		finish_test("activity timeout", err_cnt - start);

		$display("%0d tests run, %0d passed, %0d failed, %0d errors",
			tests_run, tests_run - tests_failed, tests_failed, err_cnt);
		if (err_cnt == 0 && tests_failed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

//--- logic/udp_traffic_top.sv
`timescale 1ns/1ns

module udp_traffic_top import udp_traffic_pkg::*; #(
	parameter int PAYLOAD_BYTES   = 1446,
	parameter int GAP_CYCLES      = 25_000_000,
	parameter int LED_HOLD_CYCLES = 125_000_000,
	parameter int FIFO_AW         = 9
) (
	input  logic        pll_62_5m_clk,
	input  logic        rst_n,
	// MAC write port
	input  logic        tx_wa_i,
	output logic        tx_wr_o,
	output logic [31:0] tx_data_o,
	output logic [1:0]  tx_be_o,
	output logic        tx_sop_o,
	output logic        tx_eop_o,
	output logic [15:0] tx_csum_o,
	// MAC read port
	input  logic        rx_pa_i,
	input  logic [31:0] rx_data_i,
	input  logic [1:0]  rx_be_i,
	input  logic        rx_sop_i,
	input  logic        rx_eop_i,
	// Status
	output logic        seq_err_o,
	output logic        csum_err_o,
	output logic        act_o
);

	logic                 fill_req;
	logic                 fill_ack;
	logic                 send_req;
	logic                 send_ack;
	logic [PKT_NUM_W-1:0] pkt_num;

	payload_fifo_if fifo_bus ();

	// --------------------------------------------------
	// Transmit side
	// --------------------------------------------------
	udp_traffic_ctrl #(
		.GAP_CYCLES (GAP_CYCLES)
	) u_ctrl (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.fill_ack_i    (fill_ack),
		.send_ack_i    (send_ack),
		.fill_req_o    (fill_req),
		.send_req_o    (send_req),
		.pkt_num_o     (pkt_num)
	);

	payload_gen #(
		.PAYLOAD_BYTES (PAYLOAD_BYTES)
	) u_gen (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.fill_req_i    (fill_req),
		.pkt_num_i     (pkt_num),
		.fill_ack_o    (fill_ack),
		.csum_o        (tx_csum_o),
		.fifo          (fifo_bus.writer)
	);

	payload_fifo #(
		.FIFO_AW (FIFO_AW)
	) u_fifo (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.fifo          (fifo_bus.store)
	);

	mac_tx_streamer #(
		.PAYLOAD_BYTES (PAYLOAD_BYTES)
	) u_streamer (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.send_req_i    (send_req),
		.tx_wa_i       (tx_wa_i),
		.send_ack_o    (send_ack),
		.tx_wr_o       (tx_wr_o),
		.tx_data_o     (tx_data_o),
		.tx_be_o       (tx_be_o),
		.tx_sop_o      (tx_sop_o),
		.tx_eop_o      (tx_eop_o),
		.fifo          (fifo_bus.reader)
	);

	// Receive side, runs alongside the transmit path
	rx_frame_checker #(
		.PAYLOAD_BYTES   (PAYLOAD_BYTES),
		.LED_HOLD_CYCLES (LED_HOLD_CYCLES)
	) u_checker (
		.pll_62_5m_clk (pll_62_5m_clk),
		.rst_n         (rst_n),
		.rx_pa_i       (rx_pa_i),
		.rx_data_i     (rx_data_i),
		.rx_be_i       (rx_be_i),
		.rx_sop_i      (rx_sop_i),
		.rx_eop_i      (rx_eop_i),
		.seq_err_o     (seq_err_o),
		.csum_err_o    (csum_err_o),
		.act_o         (act_o)
	);

endmodule

//--- logic/rx_frame_checker.sv
`timescale 1ns/1ns

module rx_frame_checker import udp_traffic_pkg::*; #(
	parameter int PAYLOAD_BYTES   = 1446,
	parameter int LED_HOLD_CYCLES = 125_000_000
) (
	input  logic        pll_62_5m_clk,
	input  logic        rst_n,
	input  logic        rx_pa_i,        // Word valid
	input  logic [31:0] rx_data_i,
	input  logic [1:0]  rx_be_i,
	input  logic        rx_sop_i,
	input  logic        rx_eop_i,
	output logic        seq_err_o,
	output logic        csum_err_o,
	output logic        act_o
);

	localparam int FRAME_WORDS = (PAYLOAD_BYTES + WORD_BYTES - 1) / WORD_BYTES;
	localparam int CW          = $clog2(FRAME_WORDS + 1);
	localparam int HW          = $clog2(LED_HOLD_CYCLES + 1);

	logic [CW-1:0] wcnt;        // Index of the next word in frame
	logic          is_word1;    // Carries low half of pkt number
	logic [15:0]   seq_q;
	logic [15:0]   seq_now;
	logic [15:0]   frame_cnt;
	logic [15:0]   sum_q;
	logic [15:0]   sum_now;
	payload_word_u rx_word;
	logic [HW-1:0] hold_cnt;

	assign is_word1 = !rx_sop_i && (wcnt == CW'(1));
	assign seq_now  = is_word1 ? rx_data_i[15:0] : seq_q;

	// --------------------------------------------------
	// Valid bytes and running sum
	// --------------------------------------------------
	always_comb
	begin
		rx_word.word = rx_data_i;
		if (rx_eop_i && rx_be_i != 2'd0)
			for (int j = 0; j < WORD_BYTES; j++)
				if ((WORD_BYTES - 1 - j) >= int'(rx_be_i))
					rx_word.bytes[j] = 8'd0;   // Past the last valid byte

		sum_now = oc_add16(oc_add16(rx_sop_i ? 16'd0 : sum_q, rx_word.word[31:16]),
			rx_word.word[15:0]);
	end

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wcnt       <= '0;
			seq_q      <= '0;
			sum_q      <= '0;
			frame_cnt  <= '0;
			seq_err_o  <= 1'b0;
			csum_err_o <= 1'b0;
		end
		else if (rx_pa_i)
		begin
			sum_q <= sum_now;
			if (rx_sop_i)
				wcnt <= CW'(1);
			else if (wcnt != CW'(FRAME_WORDS))
				wcnt <= wcnt + 1'b1;          // Saturates on long frames
			if (is_word1)
				seq_q <= rx_data_i[15:0];
			if (rx_eop_i)
			begin
				if (seq_now != frame_cnt)
					seq_err_o <= 1'b1;          // Sticky
				if (sum_now != CSUM_GOOD)
					csum_err_o <= 1'b1;         // Sticky
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// Activity hold
	// --------------------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			hold_cnt <= '0;
			act_o    <= 1'b0;
		end
		else if (rx_pa_i)
		begin
			hold_cnt <= HW'(LED_HOLD_CYCLES - 1);
			act_o    <= 1'b1;
		end
		else if (hold_cnt != '0)
		begin
			hold_cnt <= hold_cnt - 1'b1;
			if (hold_cnt == HW'(1))
				act_o <= 1'b0;                  // Low at hold cycle count
		end
	end

endmodule

//--- logic/mac_tx_streamer.sv
`timescale 1ns/1ns

module mac_tx_streamer import udp_traffic_pkg::*; #(
	parameter int PAYLOAD_BYTES = 1446
) (
	input  logic           pll_62_5m_clk,
	input  logic           rst_n,
	input  logic           send_req_i,
	input  logic           tx_wa_i,       // MAC write allowed
	output logic           send_ack_o,
	output logic           tx_wr_o,
	output logic [31:0]    tx_data_o,
	output logic [1:0]     tx_be_o,
	output logic           tx_sop_o,
	output logic           tx_eop_o,
	payload_fifo_if.reader fifo
);

	localparam int         FRAME_WORDS = (PAYLOAD_BYTES + WORD_BYTES - 1) / WORD_BYTES;
	localparam int         CW          = $clog2(FRAME_WORDS + 1);
	localparam logic [1:0] LAST_BE     = 2'(PAYLOAD_BYTES % WORD_BYTES);  // 0 means all four

	logic          active;
	logic [CW-1:0] wcnt;       // Words accepted so far
	logic          last_word;

	// Word moves only when MAC allows and data is there
	assign tx_wr_o   = active && tx_wa_i && !fifo.empty;
	assign fifo.rd_en = tx_wr_o;
	assign last_word = (wcnt == CW'(FRAME_WORDS - 1));

	assign tx_data_o = fifo.rd_data.word;
	assign tx_sop_o  = tx_wr_o && (wcnt == '0);
	assign tx_eop_o  = tx_wr_o && last_word;
	assign tx_be_o   = last_word ? LAST_BE : 2'd0;  // BE matters on eop only

	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active     <= 1'b0;
			send_ack_o <= 1'b0;
			wcnt       <= '0;
		end
		else if (!active)
		begin
			if (send_req_i && !send_ack_o)
				active <= 1'b1;
			else if (!send_req_i)
				send_ack_o <= 1'b0;
		end
		else if (tx_wr_o)
		begin
			if (last_word)
			begin
				active     <= 1'b0;
				send_ack_o <= 1'b1;        // Cycle after eop accepted
				wcnt       <= '0;
			end
			else
				wcnt <= wcnt + 1'b1;
		end
	end

endmodule

//--- logic/payload_fifo.sv
`timescale 1ns/1ns

module payload_fifo import udp_traffic_pkg::*; #(
	parameter int FIFO_AW = 9
) (
	input  logic          pll_62_5m_clk,
	input  logic          rst_n,
	payload_fifo_if.store fifo
);

	localparam int DEPTH = 2 ** FIFO_AW;

	payload_word_u    mem [DEPTH];
	logic [FIFO_AW:0] wr_ptr;     // Extra bit tells wrap apart from empty
	logic [FIFO_AW:0] rd_ptr;
	logic             pop;

	assign pop = fifo.rd_en && !fifo.empty;

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	always_ff @(posedge pll_62_5m_clk)
	begin
		if (fifo.wr_en)
			mem[wr_ptr[FIFO_AW-1:0]] <= fifo.wr_data;
	end

	// --------------------------------------------------
	// Pointers
	// --------------------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (fifo.wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Head shows without a read, first word fall through
	assign fifo.rd_data = mem[rd_ptr[FIFO_AW-1:0]];
	assign fifo.empty   = (wr_ptr == rd_ptr);

endmodule

//--- logic/payload_gen.sv
`timescale 1ns/1ns

module payload_gen import udp_traffic_pkg::*; #(
	parameter int PAYLOAD_BYTES = 1446
) (
	input  logic                 pll_62_5m_clk,
	input  logic                 rst_n,
	input  logic                 fill_req_i,
	input  logic [PKT_NUM_W-1:0] pkt_num_i,
	output logic                 fill_ack_o,
	output logic [15:0]          csum_o,
	payload_fifo_if.writer       fifo
);

	localparam int BW        = $clog2(PAYLOAD_BYTES + WORD_BYTES + 1);
	localparam int PAT_START = (HDR_WORDS - 1) * WORD_BYTES;  // Byte offset of pattern word

	logic          active;      // Writing words this cycle
	logic [BW-1:0] byte_cnt;    // Offset of the word being written
	logic          last_word;
	int            remain;      // Payload bytes left from this word on
	payload_word_u pat_q;       // Running pattern, pattern word and after
	payload_word_u word_raw;
	payload_word_u word_out;
	logic [15:0]   csum_q;

	assign last_word = (int'(byte_cnt) + WORD_BYTES >= PAYLOAD_BYTES);
	assign remain    = PAYLOAD_BYTES - int'(byte_cnt);

	// --------------------------------------------------
	// Word select and tail masking
	// --------------------------------------------------
	always_comb
	begin
		if (byte_cnt == '0)
			word_raw.word = pkt_num_i[PKT_NUM_W-1 -: 32];  // Pkt num high half
		else if (byte_cnt == BW'(WORD_BYTES))
			word_raw.word = pkt_num_i[31:0];               // Pkt num low half
		else
			word_raw = pat_q;

		word_out = word_raw;
		// Bytes past the payload end go out as zero
		for (int j = 0; j < WORD_BYTES; j++)
			if ((WORD_BYTES - 1 - j) >= remain)
				word_out.bytes[j] = 8'd0;
	end

	// Pattern steps every byte once per data word
	always_ff @(posedge pll_62_5m_clk)
	begin
		if (!active)
			pat_q.word <= TEST_PATTERN;
		else if (byte_cnt >= BW'(PAT_START))
			for (int j = 0; j < WORD_BYTES; j++)
				pat_q.bytes[j] <= pat_q.bytes[j] + BYTE_STEP;
	end

	// --------------------------------------------------
	// Fill handshake, byte count and checksum
	// --------------------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			active     <= 1'b0;
			fill_ack_o <= 1'b0;
			byte_cnt   <= '0;
			csum_q     <= '0;
		end
		else if (!active)
		begin
			if (fill_req_i && !fill_ack_o)
			begin
				active   <= 1'b1;          // Writes start next cycle
				byte_cnt <= '0;
				csum_q   <= '0;            // Old sum dropped at fill start
			end
			else if (!fill_req_i)
				fill_ack_o <= 1'b0;        // Four phase return to zero
		end
		else
		begin
			byte_cnt <= byte_cnt + BW'(WORD_BYTES);
			// Both 16 bit halves into the running sum
			csum_q   <= oc_add16(oc_add16(csum_q, word_out.word[31:16]),
				word_out.word[15:0]);
			if (last_word)
			begin
				active     <= 1'b0;
				fill_ack_o <= 1'b1;        // Payload complete in the FIFO
			end
		end
	end

	assign fifo.wr_en   = active;
	assign fifo.wr_data = word_out;
	assign csum_o       = csum_q;          // Held until next fill

endmodule

//--- logic/udp_traffic_ctrl.sv
`timescale 1ns/1ns

module udp_traffic_ctrl import udp_traffic_pkg::*; #(
	parameter int GAP_CYCLES = 25_000_000
) (
	input  logic                 pll_62_5m_clk,
	input  logic                 rst_n,
	input  logic                 fill_ack_i,
	input  logic                 send_ack_i,
	output logic                 fill_req_o,
	output logic                 send_req_o,
	output logic [PKT_NUM_W-1:0] pkt_num_o
);

	localparam int GW = $clog2(GAP_CYCLES + 1);

	// FSM encoding
	localparam logic [1:0] ST_IDLE    = 2'd0;  // Waiting out the gap
	localparam logic [1:0] ST_FILL    = 2'd1;  // Generator filling the FIFO
	localparam logic [1:0] ST_SEND    = 2'd2;  // Streamer draining to the MAC
	localparam logic [1:0] ST_RELEASE = 2'd3;  // Waiting for both acks to fall

	logic [1:0]    state;
	logic [GW-1:0] gap_cnt;

	// --------------------------------------------------
	// Pacing gap
	// --------------------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
			gap_cnt <= GW'(GAP_CYCLES - 1);
		else if (state == ST_SEND && send_ack_i)
			gap_cnt <= GW'(GAP_CYCLES - 1);   // Restart on send done
		else if (gap_cnt != '0)
			gap_cnt <= gap_cnt - 1'b1;
	end

	// --------------------------------------------------
	// Handshake sequencing
	// --------------------------------------------------
	always_ff @(posedge pll_62_5m_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= ST_IDLE;
			fill_req_o <= 1'b0;
			send_req_o <= 1'b0;
			pkt_num_o  <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (gap_cnt == '0)
					begin
						fill_req_o <= 1'b1;
						state      <= ST_FILL;
					end
				ST_FILL:
					if (fill_ack_i)
					begin
						fill_req_o <= 1'b0;       // Generator drops its ack after this
						send_req_o <= 1'b1;       // Payload is complete, start streaming
						state      <= ST_SEND;
					end
				ST_SEND:
					if (send_ack_i)
					begin
						send_req_o <= 1'b0;
						pkt_num_o  <= pkt_num_o + 1'b1;  // Next payload gets a new number
						state      <= ST_RELEASE;
					end
				default:
					if (!send_ack_i && !fill_ack_i)
						state <= ST_IDLE;
			endcase
		end
	end

endmodule

//--- logic/payload_fifo_if.sv
`timescale 1ns/1ns

// Word path from generator through the store to the streamer
interface payload_fifo_if;

	logic                          wr_en;     // Write strobe, one word per cycle
	udp_traffic_pkg::payload_word_u wr_data;
	logic                          rd_en;     // Pop head, ignored while empty
	udp_traffic_pkg::payload_word_u rd_data;   // Head word, always visible
	logic                          empty;

	modport writer (output wr_en, output wr_data);

	modport reader (output rd_en, input rd_data, input empty);

	modport store (
		input  wr_en,
		input  wr_data,
		input  rd_en,
		output rd_data,
		output empty
	);

endinterface

//--- logic/udp_traffic_pkg.sv
package udp_traffic_pkg;

	// --------------------------------------------------
	// Payload format
	// --------------------------------------------------
	localparam int          WORD_BYTES   = 4;            // Bytes per MAC word
	localparam int          HDR_WORDS    = 3;            // Pkt num high, pkt num low, pattern
	localparam int          PKT_NUM_W    = 64;           // Packet number width
	localparam logic [31:0] TEST_PATTERN = 32'h00_01_02_03;
	localparam logic [7:0]  BYTE_STEP    = 8'd4;         // Per byte rise between data words

	// Ones' complement sum of an intact frame
	localparam logic [15:0] CSUM_GOOD = 16'hFFFF;

	// One MAC word, seen whole or as bytes
	// Byte 3 goes out first on the wire
	typedef union packed {
		logic [31:0]      word;
		logic [3:0][7:0]  bytes;
	} payload_word_u;

	// 16 bit add with end around carry
	// One fold is enough for two operands
	function automatic logic [15:0] oc_add16(input logic [15:0] a, input logic [15:0] b);
		logic [16:0] s;
		s = {1'b0, a} + {1'b0, b};
		return s[15:0] + {15'd0, s[16]};
	endfunction

endpackage
